/* Makefile */
SIM      = verilator
VFLAGS   = --binary --timing --assert -Wno-fatal
TOP      = pipeCoreTb
LINT_TOP = pipeCore
FILELIST = vlog.f
OBJDIR   = obj_dir
PASS_MSG = ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* rtl/coreDefs.sv */
package coreDefs;

	parameter int regIdxW = 5;

	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opOri     = 6'h0d,
		opLui     = 6'h0f,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeT;

	typedef enum logic [5:0] {
		fnMfhi  = 6'h10,
		fnMthi  = 6'h11,
		fnMflo  = 6'h12,
		fnMtlo  = 6'h13,
		fnMultu = 6'h19,
		fnAddu  = 6'h21,
		fnSubu  = 6'h23,
		fnOr    = 6'h25
	} functT;

	typedef enum logic [2:0] {
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluOr    = 3'd2,
		aluLui   = 3'd3,
		aluPassA = 3'd4
	} aluOpT;

	typedef enum logic [1:0] {
		fwdNone  = 2'b00,
		fwdExMem = 2'b01,
		fwdMemWb = 2'b10
	} fwdSelT;

	// HI/LO read source, one half or a single-half write per stage
	typedef enum logic [2:0] {
		hfNone  = 3'b000,
		hfExHi  = 3'b001,
		hfExLo  = 3'b010,
		hfExOne = 3'b011,
		hfWbHi  = 3'b100,
		hfWbLo  = 3'b101,
		hfWbOne = 3'b110
	} hiLoFwdT;

	typedef enum logic [1:0] {
		selLo   = 2'b00,
		selHi   = 2'b01,
		selBoth = 2'b10
	} hlWrT;

endpackage

/* rtl/decodeUnit.sv */
`timescale 1ns/1ns

module decodeUnit (
	input  logic [31:0]                   instr,
	output logic [coreDefs::regIdxW-1:0] rs,
	output logic [coreDefs::regIdxW-1:0] rt,
	output logic [coreDefs::regIdxW-1:0] destReg,
	output coreDefs::aluOpT               aluOp,
	output logic                          useImm,
	output logic                          immZeroExt,
	output logic                          regWr,
	output logic                          memRd,
	output logic                          memWr,
	output logic                          branchOp,
	output logic                          branchNe,
	output logic                          hlWr,
	output coreDefs::hlWrT                hlWrSel,
	output logic                          hlRd,
	output logic                          hlRdSel
);

	coreDefs::opcodeT op;
	coreDefs::functT  fn;
	logic special;
	logic isAddu, isSubu, isOr, isMultu;
	logic isMfhi, isMflo, isMthi, isMtlo;
	logic isOri, isLui, isLw;

	assign op      = coreDefs::opcodeT'(instr[31:26]);
	assign fn      = coreDefs::functT'(instr[5:0]);
	assign special = (op == coreDefs::opSpecial);

	assign isAddu  = special && fn == coreDefs::fnAddu;
	assign isSubu  = special && fn == coreDefs::fnSubu;
	assign isOr    = special && fn == coreDefs::fnOr;
	assign isMultu = special && fn == coreDefs::fnMultu;
	assign isMfhi  = special && fn == coreDefs::fnMfhi;
	assign isMflo  = special && fn == coreDefs::fnMflo;
	assign isMthi  = special && fn == coreDefs::fnMthi;
	assign isMtlo  = special && fn == coreDefs::fnMtlo;
	assign isOri   = (op == coreDefs::opOri);
	assign isLui   = (op == coreDefs::opLui);
	assign isLw    = (op == coreDefs::opLw);

	assign rs         = instr[25:21];
	assign rt         = instr[20:16];
	assign destReg    = special ? instr[15:11] : instr[20:16]; // rd for R-type
	assign regWr      = isAddu || isSubu || isOr || isMfhi || isMflo || isOri || isLui || isLw;
	assign useImm     = isOri || isLui || isLw || op == coreDefs::opSw;
	assign immZeroExt = isOri;
	assign memRd      = isLw;
	assign memWr      = (op == coreDefs::opSw);
	assign branchOp   = (op == coreDefs::opBeq) || (op == coreDefs::opBne);
	assign branchNe   = (op == coreDefs::opBne);
	assign hlWr       = isMultu || isMthi || isMtlo;
	assign hlWrSel    = coreDefs::hlWrT'({isMultu, isMthi}); // MTLO leaves selLo
	assign hlRd       = isMfhi || isMflo;
	assign hlRdSel    = isMfhi;

	always_comb begin
		if (isSubu)
			aluOp = coreDefs::aluSub;
		else if (isOr || isOri)
			aluOp = coreDefs::aluOr;
		else if (isLui)
			aluOp = coreDefs::aluLui;
		else if (hlRd)
			aluOp = coreDefs::aluPassA; // MFHI/MFLO value arrives on A
		else
			aluOp = coreDefs::aluAdd;
	end

endmodule

/* rtl/execUnit.sv */
`timescale 1ns/1ns

module execUnit (
	input  coreDefs::aluOpT aluOp,
	input  logic [31:0]     opA,
	input  logic [31:0]     opB,
	output logic [31:0]     aluOut,
	output logic [63:0]     product
);

	always_comb begin
		case (aluOp)
			coreDefs::aluSub:
				aluOut = opA - opB;
			coreDefs::aluOr:
				aluOut = opA | opB;
			coreDefs::aluLui:
				aluOut = {opB[15:0], 16'd0};
			coreDefs::aluPassA:
				aluOut = opA;
			default:
				aluOut = opA + opB; // ADDU and address calc
		endcase
	end

	assign product = 64'(opA) * 64'(opB); // Unsigned 32x32

endmodule

/* rtl/hazardBypass.sv */
`timescale 1ns/1ns

module hazardBypass (
	input  logic [coreDefs::regIdxW-1:0] idExRs,
	input  logic [coreDefs::regIdxW-1:0] idExRt,
	input  logic [coreDefs::regIdxW-1:0] ifIdRs,
	input  logic [coreDefs::regIdxW-1:0] ifIdRt,
	input  logic [coreDefs::regIdxW-1:0] exMemRd,
	input  logic [coreDefs::regIdxW-1:0] memWbRd,
	input  logic                          exMemRegWr,
	input  logic                          memWbRegWr,
	input  logic                          branchOp,
	input  logic                          idExHlRdSel,
	input  logic                          exMemHlWr,
	input  coreDefs::hlWrT                exMemHlSel,
	input  logic                          memWbHlWr,
	input  coreDefs::hlWrT                memWbHlSel,
	output coreDefs::fwdSelT              exFwdA,
	output coreDefs::fwdSelT              exFwdB,
	output logic                          idFwdA,
	output logic                          idFwdB,
	output coreDefs::hiLoFwdT             hiLoFwd
);

	coreDefs::hlWrT rdHalf;
	logic exMemBoth, memWbBoth;

	function automatic coreDefs::fwdSelT exSel(input logic [coreDefs::regIdxW-1:0] src);
		if (exMemRegWr && exMemRd != '0 && exMemRd == src)
			return coreDefs::fwdExMem; // Youngest writer wins
		else if (memWbRegWr && memWbRd != '0 && memWbRd == src)
			return coreDefs::fwdMemWb;
		return coreDefs::fwdNone;
	endfunction

	always_comb begin
		exFwdA = exSel(idExRs);
		exFwdB = exSel(idExRt);
	end

	// Branch compare only sees EX/MEM, older results come through the register file
	assign idFwdA = branchOp && exMemRegWr && exMemRd != '0 && exMemRd == ifIdRs;
	assign idFwdB = branchOp && exMemRegWr && exMemRd != '0 && exMemRd == ifIdRt;

	assign rdHalf    = coreDefs::hlWrT'({1'b0, idExHlRdSel});
	assign exMemBoth = exMemHlWr && exMemHlSel == coreDefs::selBoth;
	assign memWbBoth = memWbHlWr && memWbHlSel == coreDefs::selBoth;

	always_comb begin
		if (exMemBoth && idExHlRdSel)
			hiLoFwd = coreDefs::hfExHi;
		else if (exMemBoth)
			hiLoFwd = coreDefs::hfExLo;
		else if (exMemHlWr && exMemHlSel == rdHalf)
			hiLoFwd = coreDefs::hfExOne; // MTHI/MTLO of the same half
		else if (memWbBoth && idExHlRdSel)
			hiLoFwd = coreDefs::hfWbHi;
		else if (memWbBoth)
			hiLoFwd = coreDefs::hfWbLo;
		else if (memWbHlWr && memWbHlSel == rdHalf)
			hiLoFwd = coreDefs::hfWbOne;
		else
			hiLoFwd = coreDefs::hfNone;
	end

endmodule

/* rtl/hazardStall.sv */
`timescale 1ns/1ns

module hazardStall (
	input  logic [coreDefs::regIdxW-1:0] idExRt,
	input  logic [coreDefs::regIdxW-1:0] exMemRt,
	input  logic [coreDefs::regIdxW-1:0] ifIdRs,
	input  logic [coreDefs::regIdxW-1:0] ifIdRt,
	input  logic                          idExMemRd,
	input  logic                          exMemMemRd,
	input  logic                          idExRegWr,
	input  logic                          branchOp,
	output logic                          stall
);

	logic idExHit;
	logic exMemHit;
	logic loadUse;
	logic branchAlu;
	logic branchLoad;

	assign idExHit  = idExRt != '0 && (idExRt == ifIdRs || idExRt == ifIdRt);
	assign exMemHit = exMemRt != '0 && (exMemRt == ifIdRs || exMemRt == ifIdRt);

	assign loadUse    = idExMemRd && idExHit; // Load data not ready for EX
	assign branchAlu  = branchOp && idExRegWr && idExHit; // Result still in EX
	assign branchLoad = branchOp && exMemMemRd && exMemHit; // Second cycle of load-branch

	assign stall = loadUse || branchAlu || branchLoad;

endmodule

/* rtl/hiLoUnit.sv */
`timescale 1ns/1ns

module hiLoUnit (
	input  logic                clk,
	input  logic                rstN,
	input  logic                wrEn,
	input  coreDefs::hlWrT      wrSel,
	input  logic [31:0]         wrLo,
	input  logic [31:0]         wrHi,
	output logic [31:0]         hi,
	output logic [31:0]         lo
);

	logic wrHiHalf;
	logic wrLoHalf;

	assign wrHiHalf = wrEn && (wrSel == coreDefs::selHi || wrSel == coreDefs::selBoth);
	assign wrLoHalf = wrEn && (wrSel == coreDefs::selLo || wrSel == coreDefs::selBoth);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hi <= '0;
			lo <= '0;
		end else begin
			if (wrHiHalf)
				hi <= wrHi; // MULTU upper word or MTHI
			if (wrLoHalf)
				lo <= wrLo; // MULTU lower word or MTLO
		end
	end

endmodule

/* rtl/pipeCore.sv */
`timescale 1ns/1ns

module pipeCore #(
	parameter int dmemDepth = 16
) (
	input  logic                          clk,
	input  logic                          rstN,
	output logic [31:0]                   imemAddr,
	input  logic [31:0]                   imemData,
	output logic                          wbValid,
	output logic [coreDefs::regIdxW-1:0] wbReg,
	output logic [31:0]                   wbData,
	output logic                          hlValid,
	output logic [31:0]                   hlHi,
	output logic [31:0]                   hlLo
);

	localparam int dmemAw = $clog2(dmemDepth);

	logic [31:0] pc;
	logic ifIdValid;
	logic [31:0] ifIdInstr, ifIdPc;

	logic [31:0] idInstr, idImm, rfDataA, rfDataB, brOpA, brOpB, brTarget;
	logic [coreDefs::regIdxW-1:0] idRs, idRt, idDest;
	coreDefs::aluOpT idAluOp;
	coreDefs::hlWrT idHlWrSel;
	logic idUseImm, idImmZeroExt, idRegWr, idMemRd, idMemWr;
	logic idBranchOp, idBranchNe, idHlWr, idHlRd, idHlRdSel;
	logic idFwdA, idFwdB, stall, brTaken;

	logic [coreDefs::regIdxW-1:0] idExRs, idExRt, idExRd;
	logic [31:0] idExA, idExB, idExImm;
	coreDefs::aluOpT idExAluOp;
	coreDefs::hlWrT idExHlSel;
	logic idExUseImm, idExRegWr, idExMemRd, idExMemWr, idExHlWr, idExHlRd, idExHlRdSel;

	coreDefs::fwdSelT exFwdA, exFwdB;
	coreDefs::hiLoFwdT hiLoFwd;
	logic [31:0] exA, exB, hlRdVal, aluA, aluB, aluOut, hiReg, loReg;
	logic [63:0] product;

	logic [coreDefs::regIdxW-1:0] exMemRd;
	logic [31:0] exMemAluOut, exMemStore, exMemHlHi, exMemHlLo;
	coreDefs::hlWrT exMemHlSel;
	logic exMemRegWr, exMemMemRd, exMemMemWr, exMemHlWr;

	logic [31:0] dmem [dmemDepth];
	logic [dmemAw-1:0] dmemIdx;

	logic [coreDefs::regIdxW-1:0] memWbRd;
	logic [31:0] memWbResult, memWbHlHi, memWbHlLo;
	coreDefs::hlWrT memWbHlSel;
	logic memWbRegWr, memWbHlWr;

	function automatic logic [31:0] fwdMux(input coreDefs::fwdSelT sel, input logic [31:0] regVal);
		case (sel)
			coreDefs::fwdExMem:
				return exMemAluOut;
			coreDefs::fwdMemWb:
				return memWbResult;
			default:
				return regVal;
		endcase
	endfunction

	assign imemAddr = pc; // Word address
	assign idInstr  = ifIdValid ? ifIdInstr : '0; // Empty slot decodes as no-op
	assign idImm    = idImmZeroExt ? {16'd0, idInstr[15:0]} : {{16{idInstr[15]}}, idInstr[15:0]};
	assign brOpA    = idFwdA ? exMemAluOut : rfDataA;
	assign brOpB    = idFwdB ? exMemAluOut : rfDataB;
	assign brTaken  = idBranchOp && ((brOpA == brOpB) != idBranchNe);
	assign brTarget = ifIdPc + 32'd1 + idImm; // Relative to the delay slot

	always_comb begin
		exA = fwdMux(exFwdA, idExA);
		exB = fwdMux(exFwdB, idExB);
		case (hiLoFwd)
			coreDefs::hfExHi:
				hlRdVal = exMemHlHi;
			coreDefs::hfExLo, coreDefs::hfExOne:
				hlRdVal = exMemHlLo;
			coreDefs::hfWbHi:
				hlRdVal = memWbHlHi;
			coreDefs::hfWbLo, coreDefs::hfWbOne:
				hlRdVal = memWbHlLo;
			default:
				hlRdVal = idExHlRdSel ? hiReg : loReg;
		endcase
	end

	assign aluA    = idExHlRd ? hlRdVal : exA;
	assign aluB    = idExUseImm ? idExImm : exB;
	assign dmemIdx = dmemAw'(exMemAluOut[31:2] % 30'(dmemDepth));

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			ifIdValid <= 1'b0;
			idExRegWr <= 1'b0;
			idExMemRd <= 1'b0;
			idExMemWr <= 1'b0;
			idExHlWr <= 1'b0;
			exMemRegWr <= 1'b0;
			exMemMemRd <= 1'b0;
			exMemMemWr <= 1'b0;
			exMemHlWr <= 1'b0;
			memWbRegWr <= 1'b0;
			memWbHlWr <= 1'b0;
		end else begin
			if (!stall) begin
				pc <= brTaken ? brTarget : pc + 32'd1;
				ifIdValid <= 1'b1;
			end
			idExRegWr <= idRegWr && !stall; // Bubble on stall
			idExMemRd <= idMemRd && !stall;
			idExMemWr <= idMemWr && !stall;
			idExHlWr <= idHlWr && !stall;
			exMemRegWr <= idExRegWr;
			exMemMemRd <= idExMemRd;
			exMemMemWr <= idExMemWr;
			exMemHlWr <= idExHlWr;
			memWbRegWr <= exMemRegWr;
			memWbHlWr <= exMemHlWr;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ifIdInstr <= imemData;
			ifIdPc <= pc;
		end
		idExRs <= idRs;
		idExRt <= idRt;
		idExRd <= idDest;
		idExA <= rfDataA;
		idExB <= rfDataB;
		idExImm <= idImm;
		idExAluOp <= idAluOp;
		idExUseImm <= idUseImm;
		idExHlSel <= idHlWrSel;
		idExHlRd <= idHlRd;
		idExHlRdSel <= idHlRdSel;
		exMemRd <= idExRd;
		exMemAluOut <= aluOut;
		exMemStore <= exB;
		exMemHlSel <= idExHlSel;
		// Single-half writes carry the rs value in both fields
		exMemHlHi <= (idExHlSel == coreDefs::selBoth) ? product[63:32] : exA;
		exMemHlLo <= (idExHlSel == coreDefs::selBoth) ? product[31:0] : exA;
		if (exMemMemWr)
			dmem[dmemIdx] <= exMemStore;
		memWbRd <= exMemRd;
		memWbResult <= exMemMemRd ? dmem[dmemIdx] : exMemAluOut;
		memWbHlSel <= exMemHlSel;
		memWbHlHi <= exMemHlHi;
		memWbHlLo <= exMemHlLo;
	end

	assign wbValid = memWbRegWr && memWbRd != '0;
	assign wbReg   = memWbRd;
	assign wbData  = memWbResult;
	assign hlValid = memWbHlWr;
	assign hlHi    = (memWbHlSel == coreDefs::selLo) ? hiReg : memWbHlHi; // Pair after commit
	assign hlLo    = (memWbHlSel == coreDefs::selHi) ? loReg : memWbHlLo;

	regFile uRegFile (
		.clk(clk), .rstN(rstN),
		.rdAddrA(idRs), .rdAddrB(idRt),
		.rdDataA(rfDataA), .rdDataB(rfDataB),
		.wrEn(memWbRegWr), .wrAddr(memWbRd), .wrData(memWbResult)
	);

	hiLoUnit uHiLo (
		.clk(clk), .rstN(rstN),
		.wrEn(memWbHlWr), .wrSel(memWbHlSel), .wrLo(memWbHlLo), .wrHi(memWbHlHi),
		.hi(hiReg), .lo(loReg)
	);

	decodeUnit uDecode (
		.instr(idInstr), .rs(idRs), .rt(idRt), .destReg(idDest),
		.aluOp(idAluOp), .useImm(idUseImm), .immZeroExt(idImmZeroExt),
		.regWr(idRegWr), .memRd(idMemRd), .memWr(idMemWr),
		.branchOp(idBranchOp), .branchNe(idBranchNe),
		.hlWr(idHlWr), .hlWrSel(idHlWrSel), .hlRd(idHlRd), .hlRdSel(idHlRdSel)
	);

	hazardBypass uBypass (
		.idExRs(idExRs), .idExRt(idExRt), .ifIdRs(idRs), .ifIdRt(idRt),
		.exMemRd(exMemRd), .memWbRd(memWbRd),
		.exMemRegWr(exMemRegWr), .memWbRegWr(memWbRegWr), .branchOp(idBranchOp),
		.idExHlRdSel(idExHlRdSel), .exMemHlWr(exMemHlWr), .exMemHlSel(exMemHlSel),
		.memWbHlWr(memWbHlWr), .memWbHlSel(memWbHlSel),
		.exFwdA(exFwdA), .exFwdB(exFwdB), .idFwdA(idFwdA), .idFwdB(idFwdB),
		.hiLoFwd(hiLoFwd)
	);

	// Destination index stands in for rt, the two match for loads
	hazardStall uStall (
		.idExRt(idExRd), .exMemRt(exMemRd), .ifIdRs(idRs), .ifIdRt(idRt),
		.idExMemRd(idExMemRd), .exMemMemRd(exMemMemRd), .idExRegWr(idExRegWr),
		.branchOp(idBranchOp), .stall(stall)
	);

	execUnit uExec (
		.aluOp(idExAluOp), .opA(aluA), .opB(aluB), .aluOut(aluOut), .product(product)
	);

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ns

module regFile (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic [coreDefs::regIdxW-1:0] rdAddrA,
	input  logic [coreDefs::regIdxW-1:0] rdAddrB,
	output logic [31:0]                   rdDataA,
	output logic [31:0]                   rdDataB,
	input  logic                          wrEn,
	input  logic [coreDefs::regIdxW-1:0] wrAddr,
	input  logic [31:0]                   wrData
);

	logic [31:0] regs [32];

	function automatic logic [31:0] readPort(input logic [coreDefs::regIdxW-1:0] addr);
		if (addr == '0)
			return '0; // r0 reads as zero
		else if (wrEn && wrAddr == addr)
			return wrData; // WB value seen by ID in the same cycle
		return regs[addr];
	endfunction

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	always_comb begin
		rdDataA = readPort(rdAddrA);
		rdDataB = readPort(rdAddrB);
	end

endmodule

/* testbench/pipeCoreTb.sv */
`timescale 1ns/1ns

module pipeCoreTb;

	localparam int dmemDepth = 16;
	localparam int romDepth  = 64;
	localparam int wbW       = coreDefs::regIdxW + 32;

	logic clk = 1'b0;
	logic rstN = 1'b0;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	logic wbValid;
	logic [coreDefs::regIdxW-1:0] wbReg;
	logic [31:0] wbData;
	logic hlValid;
	logic [31:0] hlHi;
	logic [31:0] hlLo;

	logic [31:0] rom [romDepth];
	int progLen = 0;
	int progTotal = 0; // Sizes the watchdog
	logic [31:0] lfsr = 32'h4974_373d;
	string testName = "reset";

	logic [wbW-1:0] wbQ [$]; // Register index and data in program order
	logic [63:0] hlQ [$]; // HI and LO after each write
	int errCount = 0;
	int checkCount = 0;
	int testsRun = 0;
	int testsFailed = 0;

	always #2 clk = ~clk;

	assign imemData = (imemAddr < 32'(progLen)) ? rom[imemAddr[5:0]] : 32'h0; // NOP past the end

	pipeCore #(.dmemDepth(dmemDepth)) dut (
		.clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.hlValid(hlValid), .hlHi(hlHi), .hlLo(hlLo)
	);

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // Taps 32 22 2 1
	endfunction

	function automatic logic [15:0] randImm();
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsrStep(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] encodeR(input coreDefs::functT fn, input int rd, input int rs,
			input int rt);
		return {coreDefs::opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(input coreDefs::opcodeT op, input int rt, input int rs,
			input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	task automatic emit(input logic [31:0] instr);
		rom[progLen] = instr;
		progLen++;
		progTotal++;
	endtask

	// Sequential ISA model with the delay slot
	task automatic runModel();
		logic [31:0] regs [32];
		logic [31:0] mem [dmemDepth];
		logic [31:0] hi, lo, ins, a, b, simm, res;
		logic [63:0] prod;
		logic [4:0] dest;
		logic wr, taken, jumpPending;
		int pc, jumpTo, steps;
		coreDefs::opcodeT op;
		coreDefs::functT fn;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < dmemDepth; i++)
			mem[i] = '0;
		hi = '0;
		lo = '0;
		pc = 0;
		jumpTo = 0;
		steps = 0;
		jumpPending = 1'b0;
		wbQ.delete();
		hlQ.delete();
		while (pc < progLen && steps < 4 * romDepth) begin
			ins = rom[pc];
			op = coreDefs::opcodeT'(ins[31:26]);
			fn = coreDefs::functT'(ins[5:0]);
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			simm = {{16{ins[15]}}, ins[15:0]};
			dest = ins[20:16];
			res = '0;
			wr = 1'b0;
			taken = 1'b0;
			case (op)
				coreDefs::opSpecial: begin
					dest = ins[15:11];
					case (fn)
						coreDefs::fnAddu: begin
							res = a + b;
							wr = 1'b1;
						end
						coreDefs::fnSubu: begin
							res = a - b;
							wr = 1'b1;
						end
						coreDefs::fnOr: begin
							res = a | b;
							wr = 1'b1;
						end
						coreDefs::fnMfhi: begin
							res = hi;
							wr = 1'b1;
						end
						coreDefs::fnMflo: begin
							res = lo;
							wr = 1'b1;
						end
						coreDefs::fnMthi: begin
							hi = a;
							hlQ.push_back({hi, lo});
						end
						coreDefs::fnMtlo: begin
							lo = a;
							hlQ.push_back({hi, lo});
						end
						coreDefs::fnMultu: begin
							prod = 64'(a) * 64'(b);
							hi = prod[63:32];
							lo = prod[31:0];
							hlQ.push_back({hi, lo});
						end
						default: ;
					endcase
				end
				coreDefs::opOri: begin
					res = a | {16'd0, ins[15:0]};
					wr = 1'b1;
				end
				coreDefs::opLui: begin
					res = {ins[15:0], 16'd0};
					wr = 1'b1;
				end
				coreDefs::opLw: begin
					res = mem[((a + simm) >> 2) % dmemDepth];
					wr = 1'b1;
				end
				coreDefs::opSw:  mem[((a + simm) >> 2) % dmemDepth] = b; // Byte address into word memory
				coreDefs::opBeq: taken = (a == b);
				coreDefs::opBne: taken = (a != b);
				default: ;
			endcase
			if (wr && dest != 0) begin
				regs[dest] = res;
				wbQ.push_back({dest, res});
			end
			if (jumpPending) begin
				pc = jumpTo;
				jumpPending = 1'b0;
			end else begin
				pc++;
			end
			if (taken) begin
				jumpPending = 1'b1;
				jumpTo = pc + int'(simm); // pc now points at the delay slot
			end
			steps++;
		end
	endtask

	task automatic startTest(input string name);
		@(negedge clk);
		rstN = 1'b0; // Pipeline cleared before the ROM changes
		testName = name;
		progLen = 0;
		for (int i = 0; i < romDepth; i++)
			rom[i] = 32'h0;
	endtask

	task automatic runTest();
		int errStart;
		int nWb;
		int nHl;
		errStart = errCount;
		runModel();
		nWb = wbQ.size();
		nHl = hlQ.size();
		repeat (4) @(negedge clk);
		rstN = 1'b1;
		// Done once both queues drained and the last instruction is past WB
		while (wbQ.size() != 0 || hlQ.size() != 0 || imemAddr < 32'(progLen + 6))
			@(negedge clk);
		testsRun++;
		if (errCount != errStart)
			testsFailed++;
		$display("%s: %0d instructions, %0d retirements, %0d HI/LO commits, %s",
			testName, progLen, nWb, nHl, (errCount == errStart) ? "ok" : "failed");
	endtask

	task automatic buildAluFwd();
		emit(encodeI(coreDefs::opOri, 1, 0, randImm()));
		emit(encodeI(coreDefs::opLui, 2, 0, randImm()));
		for (int k = 0; k < 3; k++) begin
			emit(encodeR(coreDefs::fnOr, 3, 1, 2)); // B from EX/MEM and A from MEM/WB
			emit(encodeR(coreDefs::fnAddu, 4, 3, 1));
			emit(encodeR(coreDefs::fnSubu, 5, 4, 3));
			emit(encodeI(coreDefs::opOri, 1, 5, randImm()));
			emit(encodeI(coreDefs::opLui, 2, 0, randImm()));
			emit(encodeR(coreDefs::fnAddu, 2, 2, 1));
		end
	endtask

	task automatic buildLoadUse();
		emit(encodeI(coreDefs::opOri, 1, 0, 16'h0010)); // Base address of word 4
		emit(encodeI(coreDefs::opLui, 2, 0, randImm()));
		emit(encodeI(coreDefs::opOri, 2, 2, randImm()));
		emit(encodeI(coreDefs::opSw, 2, 1, 16'h0000));
		emit(encodeI(coreDefs::opLw, 3, 1, 16'h0000)); // Load right behind the store
		emit(encodeR(coreDefs::fnAddu, 4, 3, 2));
		emit(encodeI(coreDefs::opLw, 5, 1, 16'h0000));
		emit(encodeR(coreDefs::fnSubu, 6, 1, 5)); // Load-use on rt
		emit(encodeI(coreDefs::opOri, 7, 0, 16'h0007));
		emit(encodeI(coreDefs::opSw, 4, 1, 16'hfffc)); // Negative offset to word 3
		emit(encodeI(coreDefs::opLw, 8, 0, 16'h000c));
		emit(encodeI(coreDefs::opSw, 8, 1, 16'h0004)); // Load-use on store data
		emit(encodeI(coreDefs::opLw, 9, 1, 16'h0004));
		emit(encodeR(coreDefs::fnOr, 10, 9, 8));
	endtask

	task automatic buildBranch();
		emit(encodeI(coreDefs::opOri, 1, 0, 16'h0005));
		emit(encodeI(coreDefs::opOri, 2, 0, 16'h0005));
		emit(encodeI(coreDefs::opBeq, 2, 1, 16'h0002)); // ALU dependent and taken
		emit(encodeI(coreDefs::opOri, 3, 0, 16'h0001)); // Delay slot
		emit(encodeI(coreDefs::opOri, 4, 0, 16'h0002)); // Skipped
		emit(encodeI(coreDefs::opSw, 1, 0, 16'h0000));
		emit(encodeI(coreDefs::opLw, 5, 0, 16'h0000));
		emit(encodeI(coreDefs::opBne, 1, 5, 16'h0002)); // Load dependent and not taken
		emit(encodeI(coreDefs::opOri, 6, 0, 16'h0003));
		emit(encodeI(coreDefs::opOri, 7, 0, 16'h0004));
		emit(encodeI(coreDefs::opLw, 8, 0, 16'h0000));
		emit(encodeI(coreDefs::opBeq, 1, 8, 16'h0002)); // Load dependent and taken
		emit(encodeR(coreDefs::fnAddu, 9, 8, 1));
		emit(encodeI(coreDefs::opOri, 10, 0, 16'h0005));
		emit(encodeI(coreDefs::opOri, 11, 0, randImm()));
		emit(encodeI(coreDefs::opBne, 0, 11, 16'h0002)); // Outcome set by the random value
		emit(encodeR(coreDefs::fnOr, 12, 11, 1));
		emit(encodeI(coreDefs::opOri, 13, 0, 16'h0006));
		emit(encodeI(coreDefs::opOri, 14, 0, 16'h0007));
	endtask

	task automatic buildHiLo();
		emit(encodeI(coreDefs::opOri, 1, 0, randImm()));
		emit(encodeI(coreDefs::opLui, 2, 0, randImm()));
		emit(encodeI(coreDefs::opOri, 2, 2, randImm()));
		emit(encodeR(coreDefs::fnMultu, 0, 1, 2));
		emit(encodeR(coreDefs::fnMfhi, 3, 0, 0)); // Both halves from EX/MEM
		emit(encodeR(coreDefs::fnMflo, 4, 0, 0));
		emit(encodeI(coreDefs::opOri, 5, 0, randImm()));
		emit(encodeR(coreDefs::fnMthi, 0, 5, 0));
		emit(encodeR(coreDefs::fnMfhi, 6, 0, 0)); // Distance 1
		emit(encodeR(coreDefs::fnMtlo, 0, 1, 0));
		emit(encodeI(coreDefs::opOri, 7, 0, 16'h0001));
		emit(encodeR(coreDefs::fnMflo, 8, 0, 0)); // Distance 2
		emit(encodeR(coreDefs::fnMthi, 0, 2, 0));
		emit(encodeR(coreDefs::fnAddu, 9, 1, 2));
		emit(encodeR(coreDefs::fnMfhi, 10, 0, 0));
		emit(encodeR(coreDefs::fnMtlo, 0, 5, 0));
		emit(encodeR(coreDefs::fnMflo, 11, 0, 0));
		emit(encodeR(coreDefs::fnMultu, 0, 5, 2));
		emit(encodeR(coreDefs::fnMtlo, 0, 1, 0));
		emit(encodeR(coreDefs::fnMfhi, 12, 0, 0)); // HI from MULTU in MEM/WB
		emit(encodeR(coreDefs::fnMflo, 13, 0, 0)); // LO from MTLO in MEM/WB
		emit(encodeR(coreDefs::fnMultu, 0, 2, 1));
		emit(encodeR(coreDefs::fnMflo, 14, 0, 0)); // LO half of MULTU in EX/MEM
	endtask

	task automatic buildZeroReg();
		emit(encodeI(coreDefs::opOri, 0, 0, randImm() | 16'h0001));
		emit(encodeR(coreDefs::fnAddu, 1, 0, 0)); // r0 in EX/MEM
		emit(encodeI(coreDefs::opLui, 0, 0, 16'h8001));
		emit(encodeI(coreDefs::opOri, 3, 0, randImm()));
		emit(encodeR(coreDefs::fnAddu, 0, 3, 3));
		emit(encodeR(coreDefs::fnSubu, 4, 3, 0));
		emit(encodeR(coreDefs::fnOr, 5, 0, 3)); // r0 in MEM/WB
	endtask

	always @(posedge clk) begin : checkOutputs
		logic [wbW-1:0] expWb;
		logic [63:0] expHl;
		if (rstN && wbValid) begin
			assert (wbQ.size() != 0) else begin
				$display("Unexpected retirement in %s: r%0d written with %h",
					testName, wbReg, wbData);
				errCount++;
			end
			if (wbQ.size() != 0) begin
				expWb = wbQ.pop_front();
				checkCount++;
				assert ({wbReg, wbData} == expWb) else begin
					$display("Mismatch in %s: expected r%0d = %h, actual r%0d = %h", testName,
						expWb[wbW-1:32], expWb[31:0], wbReg, wbData);
					errCount++;
				end
			end
		end
		if (rstN && hlValid) begin
			assert (hlQ.size() != 0) else begin
				$display("Unexpected HI/LO write in %s: %h/%h", testName, hlHi, hlLo);
				errCount++;
			end
			if (hlQ.size() != 0) begin
				expHl = hlQ.pop_front();
				checkCount++;
				assert ({hlHi, hlLo} == expHl) else begin
					$display("Mismatch in %s: expected hi/lo %h/%h, actual %h/%h", testName,
						expHl[63:32], expHl[31:0], hlHi, hlLo);
					errCount++;
				end
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles <= 20 * progTotal + 100) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout in %s after %0d cycles, the pipeline stopped retiring", testName, cycles);
		$display("** FAIL **");
		$finish;
	end

	initial begin : mainSeq
		for (int i = 0; i < romDepth; i++)
			rom[i] = 32'h0;
		startTest("aluFwd");
		buildAluFwd();
		runTest();
		startTest("loadUse");
		buildLoadUse();
		runTest();
		startTest("branch");
		buildBranch();
		runTest();
		startTest("hiLo");
		buildHiLo();
		runTest();
		startTest("zeroReg");
		buildZeroReg();
		runTest();
		$display("Tests run %0d, failed %0d, values checked %0d, errors %0d",
			testsRun, testsFailed, checkCount, errCount);
		if (errCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* vlog.f */
rtl/coreDefs.sv
rtl/regFile.sv
rtl/hiLoUnit.sv
rtl/decodeUnit.sv
rtl/hazardBypass.sv
rtl/hazardStall.sv
rtl/execUnit.sv
rtl/pipeCore.sv
testbench/pipeCoreTb.sv
